// File: hw/mac_pkg.sv
// mac_pkg: width constants, element, product and partial-sum types
// and the accumulator state enum for the integer MAC lane

package mac_pkg;

    // element magnitude and packed element width
    localparam int MAG_W    = 8;
    localparam int ELEM_W   = MAG_W + 2;

    // signed product of two magnitudes plus sign
    localparam int PROD_W   = 2 * MAG_W + 1;

    // partial sum, accumulator and result
    localparam int PSUM_W   = 32;

    // product, half-sum and final-sum stages
    localparam int N_STAGES = 3;

    // bit 9 zero flag, bit 8 sign, bits 7..0 magnitude
    typedef struct packed {
        logic             zero;
        logic             sign;
        logic [MAG_W-1:0] mag;
    } mac_elem_t;

    typedef logic signed [PROD_W-1:0] prod_t;

    typedef logic signed [PSUM_W-1:0] psum_t;

    typedef enum logic [1:0] {
        ACC_SUM,
        ACC_BIAS,
        ACC_OUT
    } acc_state_e;

endpackage

// File: hw/mac_pipe_ctrl.sv
// mac_pipe_ctrl: stage occupancy tracking and per-stage load enables
// with back-pressure from the output side

module mac_pipe_ctrl (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_input_valid,
    output logic                          o_input_ready,
    input  logic                          i_output_ready,
    output logic                          o_output_valid,
    output logic [mac_pkg::N_STAGES-1:0]  o_stage_en
);

    localparam int NS = mac_pkg::N_STAGES;

    logic [NS-1:0] stage_valid;
    logic [NS-1:0] stage_free;

    // a stage is free when empty or when its content moves on this cycle
    always_comb begin
        stage_free[NS-1] = ~stage_valid[NS-1] | i_output_ready;
        for (int k = NS - 2; k >= 0; k--) begin
            stage_free[k] = ~stage_valid[k] | stage_free[k+1];
        end
    end

    // stage 0 follows the input side, later stages need data upstream
    always_comb begin
        o_stage_en[0] = stage_free[0];
        for (int k = 1; k < NS; k++) begin
            o_stage_en[k] = stage_valid[k-1] & stage_free[k];
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            stage_valid <= '0;
        end else begin
            if (stage_free[0]) begin
                stage_valid[0] <= i_input_valid;
            end
            for (int k = 1; k < NS; k++) begin
                if (stage_free[k]) begin
                    stage_valid[k] <= stage_valid[k-1];
                end
            end
        end
    end

    assign o_input_ready  = o_stage_en[0];
    assign o_output_valid = stage_valid[NS-1];

endmodule

// File: hw/mac_product_stage.sv
// mac_product_stage: sign-magnitude multipliers, zero and valid masking,
// two's complement conversion and the stage 0 product register

module mac_product_stage #(
    parameter int N_LANES = 8
) (
    input  logic                                i_clk,
    input  logic                                i_load,
    input  mac_pkg::mac_elem_t [N_LANES-1:0]    i_ifm,
    input  mac_pkg::mac_elem_t [N_LANES-1:0]    i_wfm,
    input  logic [N_LANES-1:0]                  i_elem_valid,
    output mac_pkg::prod_t [N_LANES-1:0]        o_prod
);

    localparam int MAG_W = mac_pkg::MAG_W;

    logic [2*MAG_W-1:0]                 mag_prod [N_LANES];
    logic [N_LANES-1:0]                 prod_sign;
    logic [N_LANES-1:0]                 prod_kill;
    mac_pkg::prod_t [N_LANES-1:0]       prod_comb;

    ////////////////////////////////////////
    // multiply
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            mag_prod[i]  = i_ifm[i].mag * i_wfm[i].mag;
            prod_sign[i] = i_ifm[i].sign ^ i_wfm[i].sign;
            // zero flag on either side or an invalid position gives nothing
            prod_kill[i] = i_ifm[i].zero | i_wfm[i].zero | ~i_elem_valid[i];
        end
    end

    ////////////////////////////////////////
    // 2s complement and mask
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            if (prod_kill[i]) begin
                prod_comb[i] = '0;
            end else if (prod_sign[i]) begin
                prod_comb[i] = -{1'b0, mag_prod[i]};
            end else begin
                prod_comb[i] = {1'b0, mag_prod[i]};
            end
        end
    end

    ////////////////////////////////////////
    // stage 0
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            o_prod <= prod_comb;
        end
    end

endmodule

// File: hw/mac_adder_tree.sv
// mac_adder_tree: lower and upper half-sum registers at stage 1
// and the per-beat partial-sum register at stage 2

module mac_adder_tree #(
    parameter int N_LANES = 8
) (
    input  logic                            i_clk,
    input  logic                            i_load_half,
    input  logic                            i_load_sum,
    input  mac_pkg::prod_t [N_LANES-1:0]    i_prod,
    output mac_pkg::psum_t                  o_psum
);

    localparam int HALF   = N_LANES / 2;
    localparam int PROD_W = mac_pkg::PROD_W;
    localparam int PSUM_W = mac_pkg::PSUM_W;

    mac_pkg::psum_t sum_lo;
    mac_pkg::psum_t sum_hi;
    mac_pkg::psum_t half_lo;
    mac_pkg::psum_t half_hi;

    ////////////////////////////////////////
    // two trees, lower and upper positions
    ////////////////////////////////////////

    always_comb begin
        sum_lo = '0;
        sum_hi = '0;
        for (int i = 0; i < HALF; i++) begin
            sum_lo = sum_lo + {{(PSUM_W-PROD_W){i_prod[i][PROD_W-1]}}, i_prod[i]};
            sum_hi = sum_hi
                   + {{(PSUM_W-PROD_W){i_prod[i+HALF][PROD_W-1]}}, i_prod[i+HALF]};
        end
    end

    // stage 1
    always_ff @(posedge i_clk) begin
        if (i_load_half) begin
            half_lo <= sum_lo;
            half_hi <= sum_hi;
        end
    end

    ////////////////////////////////////////
    // final sum
    ////////////////////////////////////////

    // stage 2
    always_ff @(posedge i_clk) begin
        if (i_load_sum) begin
            o_psum <= half_lo + half_hi;
        end
    end

endmodule

// File: hw/mac_out_fifo.sv
// mac_out_fifo: two-entry FIFO for partial sum and accum_end
// between the pipeline and the accumulator

module mac_out_fifo (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_input_valid,
    output logic            o_input_ready,
    input  mac_pkg::psum_t  i_psum,
    input  logic            i_accum_end,
    input  logic            i_output_ready,
    output logic            o_output_valid,
    output mac_pkg::psum_t  o_psum,
    output logic            o_accum_end
);

    mac_pkg::psum_t mem_psum [2];
    logic           mem_end  [2];
    logic           wr_ptr;
    logic           rd_ptr;
    logic [1:0]     count;
    logic           push;
    logic           pop;

    // ready from fill level only, keeps downstream ready off the pipeline
    assign o_input_ready  = (count != 2'd2);
    assign o_output_valid = (count != 2'd0);

    assign push = i_input_valid & o_input_ready;
    assign pop  = o_output_valid & i_output_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem_psum[wr_ptr] <= i_psum;
            mem_end[wr_ptr]  <= i_accum_end;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    assign o_psum      = mem_psum[rd_ptr];
    assign o_accum_end = mem_end[rd_ptr];

endmodule

// File: hw/mac_psum_accumulator.sv
// mac_psum_accumulator: FSM summing partial sums per output,
// optional bias add and result handshake

module mac_psum_accumulator (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_bias_enable,
    input  logic            i_psum_valid,
    output logic            o_psum_ready,
    input  mac_pkg::psum_t  i_psum,
    input  logic            i_accum_end,
    input  logic            i_bias_valid,
    output logic            o_bias_ready,
    input  mac_pkg::psum_t  i_bias,
    input  logic            i_ofm_ready,
    output logic            o_ofm_valid,
    output mac_pkg::psum_t  o_ofm
);

    mac_pkg::acc_state_e state;
    mac_pkg::acc_state_e state_next;
    mac_pkg::psum_t      acc;
    logic                psum_fire;
    logic                bias_fire;
    logic                ofm_fire;

    assign o_psum_ready = (state == mac_pkg::ACC_SUM);
    assign o_bias_ready = (state == mac_pkg::ACC_BIAS);
    assign o_ofm_valid  = (state == mac_pkg::ACC_OUT);

    assign psum_fire = i_psum_valid & o_psum_ready;
    assign bias_fire = i_bias_valid & o_bias_ready;
    assign ofm_fire  = o_ofm_valid & i_ofm_ready;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            mac_pkg::ACC_SUM: begin
                if (psum_fire && i_accum_end) begin
                    state_next = i_bias_enable ? mac_pkg::ACC_BIAS : mac_pkg::ACC_OUT;
                end
            end
            mac_pkg::ACC_BIAS: begin
                if (bias_fire) begin
                    state_next = mac_pkg::ACC_OUT;
                end
            end
            mac_pkg::ACC_OUT: begin
                if (ofm_fire) begin
                    state_next = mac_pkg::ACC_SUM;
                end
            end
            default: begin
                state_next = mac_pkg::ACC_SUM;
            end
        endcase
    end

    ////////////////////////////////////////
    // state and accumulator
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            state <= mac_pkg::ACC_SUM;
            acc   <= '0;
        end else begin
            state <= state_next;
            // 32-bit wrap-around on every add
            if (psum_fire) begin
                acc <= acc + i_psum;
            end else if (bias_fire) begin
                acc <= acc + i_bias;
            end else if (ofm_fire) begin
                acc <= '0;
            end
        end
    end

    // result held steady while in ACC_OUT
    assign o_ofm = acc;

endmodule

// File: hw/mac_lane.sv
// mac_lane: integer MAC lane top with pipe control, product stage,
// adder tree, output FIFO and partial-sum accumulator

module mac_lane #(
    parameter int N_LANES = 8
) (
    input  logic                                i_clk,
    input  logic                                i_reset,
    output logic                                o_ifm_ready,
    input  logic                                i_ifm_valid,
    input  mac_pkg::mac_elem_t [N_LANES-1:0]    i_ifm,
    input  logic [N_LANES-1:0]                  i_elem_valid,
    input  logic                                i_accum_end,
    input  logic                                i_wfm_valid,
    input  mac_pkg::mac_elem_t [N_LANES-1:0]    i_wfm,
    input  logic                                i_bias_enable,
    output logic                                o_bias_ready,
    input  logic                                i_bias_valid,
    input  mac_pkg::psum_t                      i_bias,
    input  logic                                i_ofm_ready,
    output logic                                o_ofm_valid,
    output mac_pkg::psum_t                      o_ofm
);

    localparam int NS = mac_pkg::N_STAGES;

    logic                           pipe_in_valid;
    logic                           pipe_out_valid;
    logic [NS-1:0]                  stage_en;
    logic [NS-1:0]                  end_pipe;
    mac_pkg::prod_t [N_LANES-1:0]   prod;
    mac_pkg::psum_t                 tree_psum;
    logic                           fifo_in_ready;
    logic                           fifo_out_valid;
    mac_pkg::psum_t                 fifo_psum;
    logic                           fifo_accum_end;
    logic                           acc_psum_ready;

    // ifm and wfm are taken together
    assign pipe_in_valid = i_ifm_valid & i_wfm_valid;

    mac_pipe_ctrl u_mac_pipe_ctrl (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_input_valid  (pipe_in_valid),
        .o_input_ready  (o_ifm_ready),
        .i_output_ready (fifo_in_ready),
        .o_output_valid (pipe_out_valid),
        .o_stage_en     (stage_en)
    );

    ////////////////////////////////////////
    // accum_end travels with the data
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_reset) begin
        if (!i_reset) begin
            end_pipe <= '0;
        end else begin
            if (stage_en[0]) begin
                end_pipe[0] <= i_accum_end;
            end
            for (int k = 1; k < NS; k++) begin
                if (stage_en[k]) begin
                    end_pipe[k] <= end_pipe[k-1];
                end
            end
        end
    end

    mac_product_stage #(.N_LANES(N_LANES)) u_mac_product_stage (
        .i_clk          (i_clk),
        .i_load         (stage_en[0]),
        .i_ifm          (i_ifm),
        .i_wfm          (i_wfm),
        .i_elem_valid   (i_elem_valid),
        .o_prod         (prod)
    );

    mac_adder_tree #(.N_LANES(N_LANES)) u_mac_adder_tree (
        .i_clk          (i_clk),
        .i_load_half    (stage_en[1]),
        .i_load_sum     (stage_en[2]),
        .i_prod         (prod),
        .o_psum         (tree_psum)
    );

    mac_out_fifo u_mac_out_fifo (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_input_valid  (pipe_out_valid),
        .o_input_ready  (fifo_in_ready),
        .i_psum         (tree_psum),
        .i_accum_end    (end_pipe[NS-1]),
        .i_output_ready (acc_psum_ready),
        .o_output_valid (fifo_out_valid),
        .o_psum         (fifo_psum),
        .o_accum_end    (fifo_accum_end)
    );

    mac_psum_accumulator u_mac_psum_accumulator (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_bias_enable  (i_bias_enable),
        .i_psum_valid   (fifo_out_valid),
        .o_psum_ready   (acc_psum_ready),
        .i_psum         (fifo_psum),
        .i_accum_end    (fifo_accum_end),
        .i_bias_valid   (i_bias_valid),
        .o_bias_ready   (o_bias_ready),
        .i_bias         (i_bias),
        .i_ofm_ready    (i_ofm_ready),
        .o_ofm_valid    (o_ofm_valid),
        .o_ofm          (o_ofm)
    );

endmodule

// File: verif/tb_mac_lane.sv
// directed tests for the integer MAC lane with a dot-product
// reference model, compare tasks and a watchdog

module tb_mac_lane;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_LANES         = 8;
    localparam int CLK_PERIOD      = 20;
    localparam int MAX_BEATS       = 32;
    localparam int TOTAL_BEATS     = 1 + 5 + 20 + 20;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 50 + 2000;

    logic                               i_clk;
    logic                               i_reset;
    logic                               o_ifm_ready;
    logic                               i_ifm_valid;
    mac_pkg::mac_elem_t [N_LANES-1:0]   i_ifm;
    logic [N_LANES-1:0]                 i_elem_valid;
    logic                               i_accum_end;
    logic                               i_wfm_valid;
    mac_pkg::mac_elem_t [N_LANES-1:0]   i_wfm;
    logic                               i_bias_enable;
    logic                               o_bias_ready;
    logic                               i_bias_valid;
    mac_pkg::psum_t                     i_bias;
    logic                               i_ofm_ready;
    logic                               o_ofm_valid;
    mac_pkg::psum_t                     o_ofm;

    // beat storage and model state
    mac_pkg::mac_elem_t [N_LANES-1:0]   ifm_mem [MAX_BEATS];
    mac_pkg::mac_elem_t [N_LANES-1:0]   wfm_mem [MAX_BEATS];
    logic [N_LANES-1:0]                 ev_mem  [MAX_BEATS];
    logic                               end_mem [MAX_BEATS];
    mac_pkg::psum_t                     bias_list [MAX_BEATS];
    mac_pkg::psum_t                     exp_q [$];
    mac_pkg::psum_t                     model_acc;
    int n_groups;
    int bias_done;
    bit saw_stall;
    int errors;
    int pass_count;
    int fail_count;
    int seed;

    mac_lane #(.N_LANES(N_LANES)) uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic int elem_product(input mac_pkg::mac_elem_t a,
                                        input mac_pkg::mac_elem_t w, input logic v);
        int m;
        if (!v || a.zero || w.zero) begin
            return 0;
        end
        m = int'(a.mag) * int'(w.mag);
        return (a.sign != w.sign) ? -m : m;
    endfunction

    function automatic mac_pkg::psum_t beat_sum(input int b);
        mac_pkg::psum_t s;
        s = '0;
        for (int i = 0; i < N_LANES; i++) begin
            s = s + elem_product(ifm_mem[b][i], wfm_mem[b][i], ev_mem[b][i]);
        end
        return s;
    endfunction

    task automatic model_beat(input int b, input bit bias_en);
        model_acc = model_acc + beat_sum(b);
        if (end_mem[b]) begin
            if (bias_en) begin
                bias_list[n_groups] = $random(seed);
                model_acc = model_acc + bias_list[n_groups];
            end
            exp_q.push_back(model_acc);
            model_acc = '0;
            n_groups++;
        end
    endtask

    task automatic clear_model();
        exp_q.delete();
        model_acc = '0;
        n_groups  = 0;
        bias_done = 0;
        saw_stall = 1'b0;
    endtask

    function automatic mac_pkg::mac_elem_t rand_elem();
        mac_pkg::mac_elem_t e;
        e.zero = (($random(seed) & 7) == 0);
        e.sign = 1'($random(seed));
        e.mag  = 8'($random(seed));
        return e;
    endfunction

    task automatic gen_random_beats(input int n, input int group, input bit bias_en);
        clear_model();
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < N_LANES; i++) begin
                ifm_mem[b][i] = rand_elem();
                wfm_mem[b][i] = rand_elem();
            end
            ev_mem[b]  = N_LANES'($random(seed) | $random(seed));
            end_mem[b] = ((b % group) == group - 1);
            model_beat(b, bias_en);
        end
    endtask

    ////////////////////////////////////////
    // compare and report
    ////////////////////////////////////////

    task automatic check_psum(input string name, input mac_pkg::psum_t exp,
                              input mac_pkg::psum_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            pass_count++;
            $display("test %s finished without errors", name);
        end else begin
            fail_count++;
            $display("test %s finished with %0d errors", name, errors - err0);
        end
    endtask

    ////////////////////////////////////////
    // drivers and result collection
    ////////////////////////////////////////

    task automatic send_beats(input int n);
        for (int b = 0; b < n; b++) begin
            i_ifm_valid  <= 1'b1;
            i_wfm_valid  <= 1'b1;
            i_ifm        <= ifm_mem[b];
            i_wfm        <= wfm_mem[b];
            i_elem_valid <= ev_mem[b];
            i_accum_end  <= end_mem[b];
            @(posedge i_clk);
            while (!o_ifm_ready) begin
                saw_stall = 1'b1;
                @(posedge i_clk);
            end
        end
        i_ifm_valid <= 1'b0;
        i_wfm_valid <= 1'b0;
        i_accum_end <= 1'b0;
    endtask

    task automatic drive_bias(input string name);
        for (int g = 0; g < n_groups; g++) begin
            i_bias_valid <= 1'b1;
            i_bias       <= bias_list[g];
            @(posedge i_clk);
            while (!o_bias_ready) @(posedge i_clk);
            bias_done++;
            i_bias_valid <= 1'b0;
            // ready drops once the bias is taken
            @(posedge i_clk);
            check_bit({name, " bias_ready after transfer"}, 1'b0, o_bias_ready);
        end
    endtask

    task automatic collect_results(input string name, input bit rand_ready, input bit bias_en);
        int got;
        bit stalled;
        mac_pkg::psum_t held;
        got = 0;
        stalled = 1'b0;
        while (got < n_groups) begin
            @(posedge i_clk);
            // an unaccepted result must not move
            if (stalled) begin
                check_bit({name, " valid held"}, 1'b1, o_ofm_valid);
                check_psum({name, " data held"}, held, o_ofm);
            end
            stalled = 1'b0;
            if (o_ofm_valid) begin
                if (bias_en && bias_done <= got) begin
                    report_error($sformatf("%s: result shown before its bias transfer", name));
                end
                if (i_ofm_ready) begin
                    check_psum(name, exp_q.pop_front(), o_ofm);
                    got++;
                end else begin
                    stalled = 1'b1;
                    held = o_ofm;
                end
            end
            if (rand_ready) begin
                i_ofm_ready <= (($random(seed) & 3) == 0);
            end
        end
        i_ofm_ready <= 1'b1;
    endtask

    task automatic run_stream(input string name, input int n, input bit rand_ready,
                              input bit bias_en);
        i_bias_enable <= bias_en;
        fork
            send_beats(n);
            collect_results(name, rand_ready, bias_en);
            begin
                if (bias_en) begin
                    drive_bias(name);
                end
            end
        join
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        check_bit("reset_state ofm_valid", 1'b0, o_ofm_valid);
        check_bit("reset_state bias_ready", 1'b0, o_bias_ready);
        check_bit("reset_state ifm_ready", 1'b1, o_ifm_ready);
        report_test("reset_state", err0);
    endtask

    task automatic test_single_beat();
        int err0;
        err0 = errors;
        clear_model();
        for (int i = 0; i < N_LANES; i++) begin
            ifm_mem[0][i] = '{zero: (i == 3), sign: i[0], mag: 8'(20 * i + 15)};
            wfm_mem[0][i] = '{zero: (i == 6), sign: i[1], mag: 8'(255 - 17 * i)};
        end
        // position 5 invalid
        ev_mem[0]  = 8'b1101_1111;
        end_mem[0] = 1'b1;
        model_beat(0, 1'b0);
        run_stream("single_beat", 1, 1'b0, 1'b0);
        report_test("single_beat", err0);
    endtask

    task automatic test_bias_accumulate();
        int err0;
        err0 = errors;
        gen_random_beats(5, 5, 1'b1);
        run_stream("bias_accumulate", 5, 1'b0, 1'b1);
        report_test("bias_accumulate", err0);
    endtask

    task automatic test_back_to_back();
        int err0;
        err0 = errors;
        gen_random_beats(20, 4, 1'b0);
        run_stream("back_to_back", 20, 1'b0, 1'b0);
        report_test("back_to_back", err0);
    endtask

    task automatic test_back_pressure();
        int err0;
        err0 = errors;
        gen_random_beats(20, 4, 1'b0);
        run_stream("back_pressure", 20, 1'b1, 1'b0);
        if (!saw_stall) begin
            report_error("back_pressure: o_ifm_ready never dropped under output stalls");
        end
        report_test("back_pressure", err0);
    endtask

    initial begin
        seed          = 95;
        errors        = 0;
        pass_count    = 0;
        fail_count    = 0;
        i_reset       <= 1'b0;
        i_ifm_valid   <= 1'b0;
        i_wfm_valid   <= 1'b0;
        i_ifm         <= '0;
        i_wfm         <= '0;
        i_elem_valid  <= '0;
        i_accum_end   <= 1'b0;
        i_bias_enable <= 1'b0;
        i_bias_valid  <= 1'b0;
        i_bias        <= '0;
        i_ofm_ready   <= 1'b1;
        repeat (16) @(posedge i_clk);
        i_reset <= 1'b1;
        @(posedge i_clk);
        test_reset_state();
        test_single_beat();
        test_bias_accumulate();
        test_back_to_back();
        test_back_pressure();
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
hw/mac_pkg.sv
hw/mac_pipe_ctrl.sv
hw/mac_product_stage.sv
hw/mac_adder_tree.sv
hw/mac_out_fifo.sv
hw/mac_psum_accumulator.sv
hw/mac_lane.sv
verif/tb_mac_lane.sv
